// ==== rtl/aether_cfg_pkg.sv ====
package aether_cfg_pkg;

  // ----------------------------------------
  // Datapath sizes
  // ----------------------------------------
  localparam int DataWidth     = 8;   // Activation and weight
  localparam int WordWidth     = 16;  // Command and buffer word
  localparam int ResultWidth   = 16;
  localparam int KernelSize    = 3;
  localparam int MaxMatrixSize = 16;

  // Kernel store, two weights per word
  localparam int KernelTaps  = KernelSize * KernelSize;
  localparam int KernelWords = (KernelTaps + 1) / 2;
  localparam int KernelBytes = 2 * KernelWords;

  // Buffer depths for the largest matrix
  localparam int InBufDepth  = MaxMatrixSize * MaxMatrixSize / 2;
  localparam int OutBufDepth = (MaxMatrixSize - 2) * (MaxMatrixSize - 2);

  localparam int InAddrWidth  = $clog2(InBufDepth);
  localparam int OutAddrWidth = $clog2(OutBufDepth);
  localparam int SizeWidth    = $clog2(MaxMatrixSize + 1);  // Holds N up to 16

  // Nine int8 products need 19 bits, one spare
  localparam int AccWidth = 2 * DataWidth + 4;

  // ----------------------------------------
  // Payload types
  // ----------------------------------------
  typedef logic signed [DataWidth-1:0]   act_t;
  typedef logic        [WordWidth-1:0]   word_t;
  typedef logic signed [ResultWidth-1:0] result_t;

endpackage

// ==== rtl/aether_isa_pkg.sv ====
package aether_isa_pkg;

  // ----------------------------------------
  // Opcodes on instruction_i
  // ----------------------------------------
  localparam logic [3:0] OpNop = 4'd0;
  localparam logic [3:0] OpRst = 4'd1;
  localparam logic [3:0] OpRdr = 4'd2;  // Read register
  localparam logic [3:0] OpWrr = 4'd3;  // Write register
  localparam logic [3:0] OpLip = 4'd4;  // Load input words
  localparam logic [3:0] OpLdw = 4'd5;  // Load kernel words
  localparam logic [3:0] OpCnv = 4'd6;  // Start convolution
  localparam logic [3:0] OpRdo = 4'd7;  // Read one result

  // param_1_i codes for OpLip
  localparam logic [3:0] LipStart = 4'd0;
  localparam logic [3:0] LipCont  = 4'd1;

  // ----------------------------------------
  // Register map
  // ----------------------------------------
  localparam logic [3:0] RegVersn = 4'd0;  // Read only
  localparam logic [3:0] RegHwrid = 4'd1;  // Read only
  localparam logic [3:0] RegMsize = 4'd2;  // Matrix size N
  localparam logic [3:0] RegStats = 4'd3;  // Read only

  localparam logic [15:0] VersnValue = 16'h6C00;
  localparam logic [15:0] HwridValue = 16'hB2E9;
  localparam logic [15:0] MsizeValue = 16'd8;

  // Legal N range
  localparam logic [15:0] MsizeMin = 16'd3;
  localparam logic [15:0] MsizeMax = 16'd16;

  // Status bits in RegStats
  localparam int StatRunning = 0;
  localparam int StatDone    = 1;

endpackage

// ==== rtl/aether_buffer.sv ====
module aether_buffer #(
  parameter type payload_t = logic [15:0],
  parameter int  Depth     = 16
) (
  input  logic                     clk_i,
  input  logic                     we_i,
  input  logic [$clog2(Depth)-1:0] waddr_i,
  input  payload_t                 wdata_i,
  input  logic [$clog2(Depth)-1:0] raddr_i,
  output payload_t                 rdata_o
);

  payload_t mem [Depth];

  // Write port
  always_ff @(posedge clk_i)
  begin
    if (we_i)
    begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Registered read, one cycle latency
  always_ff @(posedge clk_i)
  begin
    rdata_o <= mem[raddr_i];
  end

  a_write_in_range: assert property (@(posedge clk_i)
    we_i |-> waddr_i < Depth)
    else $error("buffer write past Depth");

endmodule

// ==== rtl/aether_regs.sv ====
module aether_regs (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   we_i,
  input  logic [3:0]                             addr_i,
  input  aether_cfg_pkg::word_t                  wdata_i,
  input  logic                                   conv_running_i,
  input  logic                                   conv_done_i,
  input  logic                                   conv_start_i,
  output aether_cfg_pkg::word_t                  rdata_o,
  output logic [aether_cfg_pkg::SizeWidth-1:0]   matrix_size_o
);

  logic msize_ok;
  logic done_q;        // Sticky until next OpCnv
  aether_cfg_pkg::word_t stats;

  assign msize_ok = (wdata_i >= aether_isa_pkg::MsizeMin) &&
                    (wdata_i <= aether_isa_pkg::MsizeMax);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      matrix_size_o <= aether_isa_pkg::MsizeValue[aether_cfg_pkg::SizeWidth-1:0];
      done_q        <= 1'b0;
    end
    else
    begin
      if (we_i && addr_i == aether_isa_pkg::RegMsize && msize_ok)
      begin
        matrix_size_o <= wdata_i[aether_cfg_pkg::SizeWidth-1:0];
      end
      if (conv_start_i)
      begin
        done_q <= 1'b0;
      end
      else if (conv_done_i)
      begin
        done_q <= 1'b1;
      end
    end
  end

  always_comb
  begin
    stats = '0;
    stats[aether_isa_pkg::StatRunning] = conv_running_i;
    stats[aether_isa_pkg::StatDone]    = done_q;
  end

  // Combinational read port
  always_comb
  begin
    case (addr_i)
      aether_isa_pkg::RegVersn: rdata_o = aether_isa_pkg::VersnValue;
      aether_isa_pkg::RegHwrid: rdata_o = aether_isa_pkg::HwridValue;
      aether_isa_pkg::RegMsize: rdata_o = aether_cfg_pkg::word_t'(matrix_size_o);
      aether_isa_pkg::RegStats: rdata_o = stats;
      default:                  rdata_o = '0;
    endcase
  end

  a_msize_range: assert property (@(posedge clk_i) disable iff (reset_i)
    matrix_size_o >= 3 && matrix_size_o <= aether_cfg_pkg::MaxMatrixSize)
    else $error("matrix size left the legal range");

endmodule

// ==== rtl/aether_decoder.sv ====
module aether_decoder (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic [3:0]                                 instruction_i,
  input  logic [3:0]                                 param_1_i,
  input  aether_cfg_pkg::word_t                      param_2_i,
  input  aether_cfg_pkg::word_t                      reg_rdata_i,
  input  aether_cfg_pkg::result_t                    out_rdata_i,
  output logic                                       reg_we_o,
  output logic [3:0]                                 reg_addr_o,
  output aether_cfg_pkg::word_t                      reg_wdata_o,
  output logic                                       in_we_o,
  output logic [aether_cfg_pkg::InAddrWidth-1:0]     in_waddr_o,
  output aether_cfg_pkg::word_t                      in_wdata_o,
  output logic                                       kernel_load_o,
  output aether_cfg_pkg::word_t                      kernel_word_o,
  output logic                                       conv_start_o,
  output logic [aether_cfg_pkg::OutAddrWidth-1:0]    out_raddr_o,
  output logic                                       soft_reset_o,
  output aether_cfg_pkg::word_t                      data_o
);

  logic is_lip;
  logic lip_start;
  logic [aether_cfg_pkg::InAddrWidth:0] lip_addr;   // Next word to write, one spare bit
  logic [aether_cfg_pkg::InAddrWidth:0] lip_target;
  logic rdo_tag;                                     // OpRdo issued last cycle

  // ----------------------------------------
  // Strobe decode
  // ----------------------------------------
  assign soft_reset_o  = (instruction_i == aether_isa_pkg::OpRst);
  assign conv_start_o  = (instruction_i == aether_isa_pkg::OpCnv);
  assign kernel_load_o = (instruction_i == aether_isa_pkg::OpLdw);
  assign kernel_word_o = param_2_i;

  assign reg_we_o    = (instruction_i == aether_isa_pkg::OpWrr);
  assign reg_addr_o  = param_1_i;  // Shared by OpRdr and OpWrr
  assign reg_wdata_o = param_2_i;

  assign out_raddr_o = param_2_i[aether_cfg_pkg::OutAddrWidth-1:0];

  // ----------------------------------------
  // Input buffer load
  // ----------------------------------------
  assign is_lip     = (instruction_i == aether_isa_pkg::OpLip);
  assign lip_start  = (param_1_i == aether_isa_pkg::LipStart);
  assign lip_target = lip_start ? '0 : lip_addr;

  // Words past the end are dropped
  assign in_we_o    = is_lip && (lip_start || param_1_i == aether_isa_pkg::LipCont)
                      && (lip_target < aether_cfg_pkg::InBufDepth);
  assign in_waddr_o = lip_target[aether_cfg_pkg::InAddrWidth-1:0];
  assign in_wdata_o = param_2_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      lip_addr <= '0;
    end
    else if (in_we_o)
    begin
      lip_addr <= lip_target + 1'b1;
    end
  end

  // ----------------------------------------
  // Read data steering
  // ----------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rdo_tag <= 1'b0;
      data_o  <= '0;
    end
    else
    begin
      rdo_tag <= (instruction_i == aether_isa_pkg::OpRdo);
      if (instruction_i == aether_isa_pkg::OpRdr)
      begin
        data_o <= reg_rdata_i;  // Newer register read wins
      end
      else if (rdo_tag)
      begin
        data_o <= aether_cfg_pkg::word_t'(out_rdata_i);  // Buffer data one cycle late
      end
    end
  end

  // Controller never continues a load past the buffer end
  a_lip_addr_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    is_lip && param_1_i == aether_isa_pkg::LipCont
    |-> lip_addr < aether_cfg_pkg::InBufDepth)
    else $error("input write address passed InBufDepth");

endmodule

// ==== rtl/aether_conv3x3.sv ====
module aether_conv3x3 (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  logic                                     start_i,
  input  logic                                     kernel_load_i,
  input  aether_cfg_pkg::word_t                    kernel_word_i,
  input  logic [aether_cfg_pkg::SizeWidth-1:0]     matrix_size_i,
  input  aether_cfg_pkg::word_t                    in_rdata_i,
  output logic [aether_cfg_pkg::InAddrWidth-1:0]   in_raddr_o,
  output logic                                     out_we_o,
  output logic [aether_cfg_pkg::OutAddrWidth-1:0]  out_waddr_o,
  output aether_cfg_pkg::result_t                  out_wdata_o,
  output logic                                     running_o,
  output logic                                     done_o
);

  aether_cfg_pkg::act_t kernel [aether_cfg_pkg::KernelBytes];

  // Walker state
  logic                                  walk;
  logic [aether_cfg_pkg::SizeWidth-1:0]  n_q;      // N latched at start
  logic [aether_cfg_pkg::SizeWidth-1:0]  lim;
  logic [aether_cfg_pkg::SizeWidth-1:0]  row, col;
  logic [1:0]                            ti, tj;   // Tap row and column
  logic                                  last_tap, last_col, last_row;
  logic [2*aether_cfg_pkg::SizeWidth-1:0] act_idx;

  // Pipeline stages
  logic       s1_valid, s1_sel, s1_first, s1_last, s1_final;
  logic [3:0] s1_tap;
  logic       s2_valid, s2_first, s2_last, s2_final;
  aether_cfg_pkg::act_t    act;
  aether_cfg_pkg::result_t s2_prod;
  logic signed [aether_cfg_pkg::AccWidth-1:0] acc, acc_next;
  logic [aether_cfg_pkg::OutAddrWidth-1:0] out_idx;

  // ----------------------------------------
  // Kernel store
  // ----------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int b = 0; b < aether_cfg_pkg::KernelBytes; b++)
        kernel[b] <= '0;
    end
    else if (kernel_load_i)
    begin
      for (int b = 0; b < aether_cfg_pkg::KernelBytes - 2; b++)
        kernel[b] <= kernel[b+2];
      kernel[aether_cfg_pkg::KernelBytes-2] <= kernel_word_i[7:0];  // Low byte first
      kernel[aether_cfg_pkg::KernelBytes-1] <= kernel_word_i[15:8];
    end
  end

  // ----------------------------------------
  // Walker over row, column and tap
  // ----------------------------------------
  assign lim      = n_q - 3'd3;
  assign last_tap = (ti == 2'd2) && (tj == 2'd2);
  assign last_col = (col == lim);
  assign last_row = (row == lim);
  assign act_idx  = (row + ti) * n_q + (col + tj);
  assign in_raddr_o = act_idx[aether_cfg_pkg::InAddrWidth:1];  // Two activations per word

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      walk      <= 1'b0;
      running_o <= 1'b0;
      n_q       <= '0;
      row       <= '0;
      col       <= '0;
      ti        <= '0;
      tj        <= '0;
    end
    else if (start_i && !running_o)
    begin
      walk      <= 1'b1;
      running_o <= 1'b1;
      n_q       <= matrix_size_i;
      row       <= '0;
      col       <= '0;
      ti        <= '0;
      tj        <= '0;
    end
    else
    begin
      if (s2_valid && s2_final)
        running_o <= 1'b0;  // Drops with the done pulse
      if (walk)
      begin
        if (tj != 2'd2)
          tj <= tj + 1'b1;
        else
        begin
          tj <= '0;
          if (ti != 2'd2)
            ti <= ti + 1'b1;
          else
          begin
            ti <= '0;
            if (!last_col)
              col <= col + 1'b1;
            else
            begin
              col <= '0;
              row <= row + 1'b1;
              if (last_row)
                walk <= 1'b0;
            end
          end
        end
      end
    end
  end

  // ----------------------------------------
  // Read, multiply, accumulate
  // ----------------------------------------
  assign act      = s1_sel ? in_rdata_i[15:8] : in_rdata_i[7:0];
  assign acc_next = s2_first ? s2_prod : acc + s2_prod;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      out_we_o <= 1'b0;
      done_o   <= 1'b0;
      out_idx  <= '0;
    end
    else
    begin
      s1_valid <= walk;
      s2_valid <= s1_valid;
      out_we_o <= s2_valid && s2_last;
      done_o   <= s2_valid && s2_final;
      if (start_i && !running_o)
        out_idx <= '0;
      else if (s2_valid && s2_last)
        out_idx <= out_idx + 1'b1;
    end
  end

  // Payload registers
  always_ff @(posedge clk_i)
  begin
    s1_sel   <= act_idx[0];  // Odd index sits in the high byte
    s1_tap   <= 4'(ti * 3 + tj);
    s1_first <= (ti == 2'd0) && (tj == 2'd0);
    s1_last  <= last_tap;
    s1_final <= last_tap && last_col && last_row;
    s2_prod  <= act * kernel[s1_tap];
    s2_first <= s1_first;
    s2_last  <= s1_last;
    s2_final <= s1_final;
    if (s2_valid)
      acc <= acc_next;
    out_waddr_o <= out_idx;
    if (acc_next > 32767)
      out_wdata_o <= 16'sh7FFF;  // Clamp to int16
    else if (acc_next < -32768)
      out_wdata_o <= 16'sh8000;
    else
      out_wdata_o <= acc_next[aether_cfg_pkg::ResultWidth-1:0];
  end

  // A start during a run must not rewind the result pointer
  a_no_restart: assert property (@(posedge clk_i) disable iff (reset_i)
    running_o && start_i |=> out_idx >= $past(out_idx))
    else $error("start honored while running");

endmodule

// ==== rtl/aether_engine.sv ====
module aether_engine (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [3:0]            instruction_i,
  input  logic [3:0]            param_1_i,
  input  aether_cfg_pkg::word_t param_2_i,
  output aether_cfg_pkg::word_t data_o
);

  logic rst;
  logic soft_reset;

  // Register bank
  logic                                 reg_we;
  logic [3:0]                           reg_addr;
  aether_cfg_pkg::word_t                reg_wdata, reg_rdata;
  logic [aether_cfg_pkg::SizeWidth-1:0] matrix_size;

  // Input buffer
  logic                                   in_we;
  logic [aether_cfg_pkg::InAddrWidth-1:0] in_waddr, in_raddr;
  aether_cfg_pkg::word_t                  in_wdata, in_rdata;

  // Output buffer
  logic                                    out_we;
  logic [aether_cfg_pkg::OutAddrWidth-1:0] out_waddr, out_raddr;
  aether_cfg_pkg::result_t                 out_wdata, out_rdata;

  // Engine control
  logic                  kernel_load;
  aether_cfg_pkg::word_t kernel_word;
  logic                  conv_start, conv_running, conv_done;

  assign rst = reset_i || soft_reset;  // OpRst acts like reset_i

  // ----------------------------------------
  // Control
  // ----------------------------------------
  aether_decoder decoder_inst (
    .clk_i, .reset_i(rst), .instruction_i, .param_1_i, .param_2_i,
    .reg_rdata_i(reg_rdata), .out_rdata_i(out_rdata),
    .reg_we_o(reg_we), .reg_addr_o(reg_addr), .reg_wdata_o(reg_wdata),
    .in_we_o(in_we), .in_waddr_o(in_waddr), .in_wdata_o(in_wdata),
    .kernel_load_o(kernel_load), .kernel_word_o(kernel_word),
    .conv_start_o(conv_start), .out_raddr_o(out_raddr),
    .soft_reset_o(soft_reset), .data_o
  );

  aether_regs regs_inst (
    .clk_i, .reset_i(rst), .we_i(reg_we), .addr_i(reg_addr), .wdata_i(reg_wdata),
    .conv_running_i(conv_running), .conv_done_i(conv_done), .conv_start_i(conv_start),
    .rdata_o(reg_rdata), .matrix_size_o(matrix_size)
  );

  // ----------------------------------------
  // Datapath
  // ----------------------------------------
  aether_buffer #(
    .payload_t(aether_cfg_pkg::word_t), .Depth(aether_cfg_pkg::InBufDepth)
  ) in_buf_inst (
    .clk_i, .we_i(in_we), .waddr_i(in_waddr), .wdata_i(in_wdata),
    .raddr_i(in_raddr), .rdata_o(in_rdata)
  );

  aether_buffer #(
    .payload_t(aether_cfg_pkg::result_t), .Depth(aether_cfg_pkg::OutBufDepth)
  ) out_buf_inst (
    .clk_i, .we_i(out_we), .waddr_i(out_waddr), .wdata_i(out_wdata),
    .raddr_i(out_raddr), .rdata_o(out_rdata)
  );

  aether_conv3x3 conv_inst (
    .clk_i, .reset_i(rst), .start_i(conv_start),
    .kernel_load_i(kernel_load), .kernel_word_i(kernel_word),
    .matrix_size_i(matrix_size), .in_rdata_i(in_rdata), .in_raddr_o(in_raddr),
    .out_we_o(out_we), .out_waddr_o(out_waddr), .out_wdata_o(out_wdata),
    .running_o(conv_running), .done_o(conv_done)
  );

endmodule

// ==== verif/aether_clock_gen.sv ====
module aether_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  localparam int HalfPeriod  = 20;  // 40 unit period
  localparam int ResetCycles = 5;

  initial
  begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  // Synchronous reset over the first cycles
  initial
  begin
    reset_o <= 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== verif/aether_engine_tb.sv ====
module aether_engine_tb;

  localparam int StimDepth   = 512;
  localparam int ResetCycles = 5;
  localparam int Slack       = 200;

  // Record tags in the stimulus file
  localparam logic [15:0] TagEnd    = 16'h0;
  localparam logic [15:0] TagCheck  = 16'h1;  // Read and compare a register
  localparam logic [15:0] TagWrite  = 16'h2;
  localparam logic [15:0] TagMatrix = 16'h3;
  localparam logic [15:0] TagRandom = 16'h4;  // LCG filled matrix
  localparam logic [15:0] TagKernel = 16'h5;
  localparam logic [15:0] TagConv   = 16'h6;
  localparam logic [15:0] TagReset  = 16'h7;

  logic                  clk;
  logic                  reset;
  logic [3:0]            instruction;
  logic [3:0]            param_1;
  aether_cfg_pkg::word_t param_2;
  aether_cfg_pkg::word_t dut_data;

  logic [15:0] stim [StimDepth];
  int          ptr;
  int          check_count;
  int          error_count;
  int          cycle_count = 0;
  int          cycle_limit;
  logic [31:0] rng_state = 32'd20173;

  // ----------------------------------------
  // Reference model state
  // ----------------------------------------
  logic [15:0] in_words_model [aether_cfg_pkg::InBufDepth];
  logic [7:0]  act_bytes [aether_cfg_pkg::MaxMatrixSize * aether_cfg_pkg::MaxMatrixSize];
  logic [7:0]  kernel_model [aether_cfg_pkg::KernelBytes];
  int          msize_model;

  aether_clock_gen clock_gen_inst (
    .clk_o(clk),
    .reset_o(reset)
  );

  aether_engine aether_engine_inst (
    .clk_i(clk), .reset_i(reset), .instruction_i(instruction),
    .param_1_i(param_1), .param_2_i(param_2), .data_o(dut_data)
  );

  function automatic logic [15:0] fetch();
    logic [15:0] w;
    w = stim[ptr];
    ptr++;
    return w;
  endfunction

  function automatic logic [7:0] lcg_activation();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return {1'b0, rng_state[22:16]};  // Nonnegative int8
  endfunction

  // Activation k sits in word k/2, odd k in the high byte
  function automatic int activation_at(input int k);
    logic [15:0]       w;
    logic signed [7:0] b;
    w = in_words_model[k / 2];
    b = (k % 2 == 1) ? w[15:8] : w[7:0];
    return int'(b);
  endfunction

  function automatic logic [15:0] expected_result(input int r, input int c, input int n);
    int                sum;
    logic signed [7:0] wt;
    sum = 0;
    for (int i = 0; i < 3; i++)
    begin
      for (int j = 0; j < 3; j++)
      begin
        wt = kernel_model[i * 3 + j];
        sum += activation_at((r + i) * n + c + j) * int'(wt);
      end
    end
    if (sum > 32767)
      sum = 32767;  // Clamp to int16
    else if (sum < -32768)
      sum = -32768;
    return sum[15:0];
  endfunction

  // Walks the records once to size the cycle limit
  function automatic int estimate_cycles();
    int          total;
    int          n;
    int          arg;
    logic [15:0] tag;
    logic [15:0] reg_idx;
    bit          finished;
    total    = 0;
    n        = aether_isa_pkg::MsizeValue;
    finished = 1'b0;
    ptr      = 0;
    while (!finished && ptr < StimDepth)
    begin
      tag = fetch();
      case (tag)
        TagCheck:
        begin
          ptr += 2;
          total += 4;
        end
        TagWrite:
        begin
          reg_idx = fetch();
          arg = fetch();
          if (reg_idx == aether_isa_pkg::RegMsize && arg >= 3 && arg <= 16)
            n = arg;
          total += 2;
        end
        TagMatrix:
        begin
          arg = fetch();
          ptr += arg * arg;
          total += arg * arg + 2;  // Two cycles per word
        end
        TagRandom:
        begin
          arg = fetch();
          total += arg * arg + 2;
        end
        TagKernel:
        begin
          ptr += 9;
          total += 10;
        end
        TagConv:  total += 12 * (n - 2) * (n - 2) + 20;  // Run plus result reads
        TagReset:
        begin
          n = aether_isa_pkg::MsizeValue;
          total += 2;
        end
        default:  finished = 1'b1;
      endcase
    end
    ptr = 0;
    return total;
  endfunction

  // ----------------------------------------
  // Command driving
  // ----------------------------------------
  task automatic issue_command(input logic [3:0] op, input logic [3:0] p1,
                               input logic [15:0] p2);
    @(posedge clk);
    instruction <= op;
    param_1     <= p1;
    param_2     <= p2;
    @(posedge clk);
    instruction <= aether_isa_pkg::OpNop;
    param_1     <= '0;
    param_2     <= '0;
  endtask

  task automatic read_register(input logic [3:0] addr, output logic [15:0] value);
    issue_command(aether_isa_pkg::OpRdr, addr, 16'd0);
    @(negedge clk);  // Valid from the cycle after the command
    value = dut_data;
  endtask

  task automatic read_result(input int idx, output logic [15:0] value);
    issue_command(aether_isa_pkg::OpRdo, 4'd0, 16'(idx));
    @(posedge clk);
    @(negedge clk);
    value = dut_data;
  endtask

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    check_count++;
    assert (actual === expected)
    else
    begin
      error_count++;
      $display("FAIL time %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic load_matrix(input int count);
    logic [15:0] word;
    logic [3:0]  code;
    for (int w = 0; w < (count + 1) / 2; w++)
    begin
      word[7:0]  = act_bytes[2 * w];
      word[15:8] = (2 * w + 1 < count) ? act_bytes[2 * w + 1] : 8'h00;  // Odd count pads
      code = (w == 0) ? aether_isa_pkg::LipStart : aether_isa_pkg::LipCont;
      issue_command(aether_isa_pkg::OpLip, code, word);
      in_words_model[w] = word;
    end
  endtask

  task automatic load_kernel();
    for (int i = 0; i < aether_cfg_pkg::KernelWords; i++)
      issue_command(aether_isa_pkg::OpLdw, 4'd0, {kernel_model[2 * i + 1], kernel_model[2 * i]});
  endtask

  task automatic run_convolution();
    int          n;
    int          m;
    logic [15:0] stats;
    logic [15:0] got;
    bit          seen_running;
    n = msize_model;
    m = n - 2;
    issue_command(aether_isa_pkg::OpCnv, 4'd0, 16'd0);
    read_register(aether_isa_pkg::RegStats, stats);
    check_value("data_o StatDone after OpCnv", 16'd0, {15'd0, stats[aether_isa_pkg::StatDone]});
    seen_running = stats[aether_isa_pkg::StatRunning];
    while (!stats[aether_isa_pkg::StatDone])
    begin
      read_register(aether_isa_pkg::RegStats, stats);
      if (stats[aether_isa_pkg::StatRunning])
        seen_running = 1'b1;
    end
    check_count++;
    assert (seen_running)
    else
    begin
      error_count++;
      $display("StatRunning was never seen set while the convolution ran");
    end
    for (int r = 0; r < m; r++)
    begin
      for (int c = 0; c < m; c++)
      begin
        read_result(r * m + c, got);
        check_value($sformatf("data_o result %0d", r * m + c), expected_result(r, c, n), got);
      end
    end
  endtask

  // ----------------------------------------
  // Record walker
  // ----------------------------------------
  initial
  begin
    logic [15:0] tag;
    logic [15:0] reg_idx;
    logic [15:0] value;
    logic [15:0] got;
    int          n;
    bit          finished;
    instruction <= aether_isa_pkg::OpNop;
    param_1     <= '0;
    param_2     <= '0;
    check_count = 0;
    error_count = 0;
    msize_model = aether_isa_pkg::MsizeValue;
    $readmemh("verif/aether_tb_input.txt", stim);
    cycle_limit = ResetCycles + 2 * estimate_cycles() + Slack;
    @(posedge clk);
    while (reset)
      @(posedge clk);
    finished = 1'b0;
    while (!finished && ptr < StimDepth)
    begin
      tag = fetch();
      case (tag)
        TagCheck:
        begin
          reg_idx = fetch();
          value = fetch();
          read_register(reg_idx[3:0], got);
          check_value($sformatf("data_o register %0d", reg_idx), value, got);
        end
        TagWrite:
        begin
          reg_idx = fetch();
          value = fetch();
          issue_command(aether_isa_pkg::OpWrr, reg_idx[3:0], value);
          if (reg_idx == aether_isa_pkg::RegMsize && value >= 3 && value <= 16)
            msize_model = value;  // Other values leave N alone
        end
        TagMatrix:
        begin
          n = fetch();
          for (int k = 0; k < n * n; k++)
          begin
            value = fetch();
            act_bytes[k] = value[7:0];
          end
          load_matrix(n * n);
        end
        TagRandom:
        begin
          n = fetch();
          for (int k = 0; k < n * n; k++)
            act_bytes[k] = lcg_activation();
          load_matrix(n * n);
        end
        TagKernel:
        begin
          for (int k = 0; k < 9; k++)
          begin
            value = fetch();
            kernel_model[k] = value[7:0];
          end
          kernel_model[9] = 8'h00;  // Pad byte of the fifth word
          load_kernel();
        end
        TagConv:  run_convolution();
        TagReset:
        begin
          issue_command(aether_isa_pkg::OpRst, 4'd0, 16'd0);
          msize_model = aether_isa_pkg::MsizeValue;
          for (int k = 0; k < aether_cfg_pkg::KernelBytes; k++)
            kernel_model[k] = 8'h00;
        end
        TagEnd:   finished = 1'b1;
        default:
        begin
          error_count++;
          $display("Unknown record tag %h at stimulus word %0d", tag, ptr - 1);
          finished = 1'b1;
        end
      endcase
    end
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("Timeout, the run did not end within %0d cycles", cycle_limit);
      $display("Checks run: %0d, errors: %0d", check_count, error_count + 1);
      $display("Testbench failed");
      $finish;
    end
  end

endmodule

// ==== verif/aether_tb_input.txt ====
// Hex records, a tag then its arguments. 1 reg exp = read and compare register,
// 2 reg val = write register, 3 n a0.. = load matrix, 4 n = LCG matrix,
// 5 w0..w8 = load kernel, 6 = convolve and check, 7 = OpRst, 0 = end
1 0 6C00  1 1 B2E9  1 2 0008  1 3 0000
2 2 0005  1 2 0005
2 2 0028  1 2 0005
2 0 1234  1 0 6C00
3 5
01 02 03 04 05
06 07 08 09 0A
0B 0C 0D 0E 0F
10 11 12 13 14
15 16 17 18 7F
5 01 02 01 00 03 00 02 01 04
6  1 3 0002
2 2 0010  1 2 0010
4 10
5 7F 7F 7F 7F 7F 7F 7F 7F 7F
6
7  1 0 6C00  1 1 B2E9  1 2 0008  1 3 0000
6
0

// ==== project.f ====
rtl/aether_cfg_pkg.sv
rtl/aether_isa_pkg.sv
rtl/aether_buffer.sv
rtl/aether_regs.sv
rtl/aether_decoder.sv
rtl/aether_conv3x3.sv
rtl/aether_engine.sv
verif/aether_clock_gen.sv
verif/aether_engine_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module aether_engine_tb -f project.f -o aether_sim

./obj_dir/aether_sim | tee sim.log

if grep -qx "Testbench passed" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
